//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_mem_subsys
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(wildcard src/*.sv) $(wildcard sim/*.sv)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) build.f
	$(VERILATOR) $(VFLAGS) -f build.f --top-module $(TOP) --Mdir $(OBJ_DIR)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TB PASSED"

clean:
	rm -rf $(OBJ_DIR)

//--- build.f
src/mem_pkg.sv
src/dcache_cpu_if.sv
src/dcache_mem_if.sv
src/data_cache.sv
src/mem_stage.sv
src/mem_subsys_top.sv
sim/mem_props.sv
sim/mem_checker.sv
sim/tb_mem_subsys.sv

//--- sim/mem_checker.sv
`timescale 1ns/1ps
`default_nettype none

module mem_checker (
  input  logic                               clk_i,
  input  logic                               rst_i,
  input  logic                               valid_i,
  input  logic                               is_load_i,
  input  logic                               is_store_i,
  input  logic                               reg_wr_en_i,
  input  mem_pkg::access_size_t              access_size_i,
  input  logic [mem_pkg::DATA_WIDTH-1:0]     alu_result_i,
  input  logic [mem_pkg::DATA_WIDTH-1:0]     rs2_data_i,
  input  logic [mem_pkg::REGISTER_WIDTH-1:0] wr_reg_i,
  input  logic                               stall_o,
  input  logic                               wb_valid_o,
  input  logic                               wb_reg_wr_en_o,
  input  logic                               wb_is_next_cycle_o,
  input  logic [mem_pkg::REGISTER_WIDTH-1:0] wb_wr_reg_o,
  input  logic [mem_pkg::DATA_WIDTH-1:0]     wb_data_from_mem_o,
  input  logic [8*16-1:0]                    test_name_i,
  output int                                 errors_o,
  output int                                 checks_o
);
  import mem_pkg::*;

  typedef struct packed {
    logic         ld;
    logic         st;
    logic         wen;
    access_size_t size;
    logic [31:0]  addr;
    logic [31:0]  data;
    logic [4:0]   rd;
  } op_t;

  op_t        pending[$];
  op_t        op;
  logic [7:0] shadow [256];

  function automatic int size_bytes(input access_size_t s);
    return (s == BYTE) ? 1 : (s == HALF) ? 2 : 4;
  endfunction

  // Little endian, zero extended.
  function automatic logic [31:0] load_ref(input logic [31:0] addr, input access_size_t s);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < size_bytes(s); i++) begin
      v[i*8 +: 8] = shadow[8'(addr + i)];
    end
    return v;
  endfunction

  initial begin
    errors_o = 0;
    checks_o = 0;
    for (int a = 0; a < 256; a++) shadow[a] = 8'((a * 13 + 90) ^ (a >> 3));
  end

  always @(posedge clk_i) begin
    if (rst_i) begin
      if (wb_is_next_cycle_o !== wb_valid_o) begin
        $display("[FAIL] %0s: wb_is_next_cycle exp %0b act %0b", test_name_i,
                 wb_valid_o, wb_is_next_cycle_o);
        errors_o++;
      end
      if (valid_i && !stall_o) begin
        pending.push_back({is_load_i, is_store_i, reg_wr_en_i, access_size_i,
                           alu_result_i, rs2_data_i, wr_reg_i});
      end
      if (wb_valid_o) begin
        if (pending.size() == 0) begin
          $display("[FAIL] %0s: write-back with no accepted operation", test_name_i);
          errors_o++;
        end else begin
          op = pending.pop_front();
          checks_o++;
          if (wb_wr_reg_o !== op.rd || wb_reg_wr_en_o !== (op.ld | op.wen)) begin
            $display("[FAIL] %0s: reg exp %0d/%0b act %0d/%0b", test_name_i,
                     op.rd, op.ld | op.wen, wb_wr_reg_o, wb_reg_wr_en_o);
            errors_o++;
          end
          if (op.ld && wb_data_from_mem_o !== load_ref(op.addr, op.size)) begin
            $display("[FAIL] %0s: load @%h exp %h act %h", test_name_i, op.addr,
                     load_ref(op.addr, op.size), wb_data_from_mem_o);
            errors_o++;
          end
          if (op.st) begin
            for (int i = 0; i < size_bytes(op.size); i++) begin
              shadow[8'(op.addr + i)] = op.data[i*8 +: 8];
            end
          end
        end
      end
    end
  end

endmodule : mem_checker

`default_nettype wire

//--- sim/mem_props.sv
`timescale 1ns/1ps
`default_nettype none

module mem_props (
  input logic                           clk_i,
  input logic                           rst_i,
  input logic                           rd_req_valid_o,
  input logic                           wr_req_valid_o,
  input logic [mem_pkg::ADDR_WIDTH-1:0] mem_req_address_o,
  input logic [mem_pkg::LINE_WIDTH-1:0] wr_line_data_o,
  input logic                           mem_gnt_i,
  input logic                           stall_o,
  input logic                           wb_valid_o,
  input logic                           wb_reg_wr_en_o
);

  // Line request held until granted.
  a_req_stable: assert property (@(posedge clk_i) disable iff (!rst_i)
    (rd_req_valid_o || wr_req_valid_o) && !mem_gnt_i |=>
      $stable(rd_req_valid_o) && $stable(wr_req_valid_o) && $stable(mem_req_address_o))
    else $error("line request changed before grant");

  a_wdata_stable: assert property (@(posedge clk_i) disable iff (!rst_i)
    wr_req_valid_o && !mem_gnt_i |=> $stable(wr_line_data_o))
    else $error("write-back data changed before grant");

  // Eviction is followed by the refill read.
  a_evict_then_fill: assert property (@(posedge clk_i) disable iff (!rst_i)
    wr_req_valid_o && mem_gnt_i |=> rd_req_valid_o)
    else $error("write-back not followed by refill read");

  a_no_wb_in_stall: assert property (@(posedge clk_i) disable iff (!rst_i)
    stall_o |-> !wb_valid_o && !wb_reg_wr_en_o)
    else $error("write-back flag raised during stall");

endmodule : mem_props

bind mem_subsys_top mem_props u_props (.*);

`default_nettype wire

//--- sim/tb_mem_subsys.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mem_subsys;
  import mem_pkg::*;

  localparam int TIMEOUT = 200;

  logic                  clk_i = 1'b0;
  logic                  rst_i = 1'b0;
  logic                  valid_i = 1'b0;
  logic                  is_load_i = 1'b0;
  logic                  is_store_i = 1'b0;
  logic                  reg_wr_en_i = 1'b0;
  access_size_t          access_size_i = WORD;
  logic [31:0]           alu_result_i = '0;
  logic [31:0]           rs2_data_i = '0;
  logic [4:0]            wr_reg_i = '0;
  logic                  mem_gnt_i = 1'b0;
  logic                  mem_rvalid_i = 1'b0;
  logic [LINE_WIDTH-1:0] mem_line_data_i = '0;
  logic                  stall_o;
  logic                  wb_valid_o;
  logic                  wb_reg_wr_en_o;
  logic                  wb_is_next_cycle_o;
  logic                  rd_req_valid_o;
  logic                  wr_req_valid_o;
  logic [4:0]            wb_wr_reg_o;
  logic [31:0]           wb_data_from_mem_o;
  logic [31:0]           mem_req_address_o;
  logic [LINE_WIDTH-1:0] wr_line_data_o;

  logic [7:0]      line_mem [256];
  logic [31:0]     lfsr_q = 32'd96903;
  logic [8*16-1:0] test_name = "reset";
  int              errors;
  int              checks;
  int              tb_errors = 0;
  int              n_pass = 0;
  int              n_fail = 0;
  int              cycles;
  int              base;
  bit              timed_out = 0;

  always #20 clk_i = ~clk_i;

  mem_subsys_top u_mem_subsys_top (.*);

  mem_checker u_checker (
    .clk_i, .rst_i, .valid_i, .is_load_i, .is_store_i, .reg_wr_en_i, .access_size_i,
    .alu_result_i, .rs2_data_i, .wr_reg_i, .stall_o, .wb_valid_o, .wb_reg_wr_en_o,
    .wb_is_next_cycle_o, .wb_wr_reg_o, .wb_data_from_mem_o, .test_name_i(test_name),
    .errors_o(errors), .checks_o(checks)
  );

  function automatic int rand_bits(input int n);
    int r;
    r = 0;
    for (int i = 0; i < n; i++) begin
      r = (r << 1) | lfsr_q[0];
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h80200003) : (lfsr_q >> 1);  // Galois step.
    end
    return r;
  endfunction

  // Line memory responder with random grant and data delays.
  always begin
    @(negedge clk_i);
    if (rd_req_valid_o || wr_req_valid_o) begin
      repeat (rand_bits(2)) @(negedge clk_i);
      mem_gnt_i = 1'b1;
      for (int b = 0; b < LINE_BYTES; b++) begin
        if (wr_req_valid_o) line_mem[{mem_req_address_o[7:4], 4'(b)}] = wr_line_data_o[b*8 +: 8];
        mem_line_data_i[b*8 +: 8] = line_mem[{mem_req_address_o[7:4], 4'(b)}];
      end
      if (rd_req_valid_o) begin
        @(negedge clk_i);
        mem_gnt_i = 1'b0;
        repeat (rand_bits(2)) @(negedge clk_i);
        mem_rvalid_i = 1'b1;
      end
      @(negedge clk_i);
      mem_gnt_i    = 1'b0;
      mem_rvalid_i = 1'b0;
    end
  end

  task automatic run_op(input bit ld, input bit st, input access_size_t sz,
                        input logic [31:0] addr, input logic [31:0] data,
                        input logic [4:0] rd, input bit wen);
    if (timed_out) return;
    @(negedge clk_i);
    valid_i       = 1'b1;
    is_load_i     = ld;
    is_store_i    = st;
    reg_wr_en_i   = wen;
    access_size_i = sz;
    alu_result_i  = addr;
    rs2_data_i    = data;
    wr_reg_i      = rd;
    cycles = 0;
    #10;
    while (!(wb_valid_o && !stall_o)) begin
      if (cycles >= TIMEOUT) begin
        $display("%0s: no write-back within timeout", test_name);
        timed_out = 1;
        return;
      end
      @(negedge clk_i);
      #10;
      cycles++;
    end
  endtask

  task automatic finish_test();
    @(negedge clk_i);
    valid_i = 1'b0;
    @(negedge clk_i);
    if (errors + tb_errors == base && !timed_out) begin
      $display("PASS %0s", test_name);
      n_pass++;
    end else begin
      $display("FAIL %0s", test_name);
      n_fail++;
    end
    base = errors + tb_errors;
  endtask

  initial begin
    logic [1:0] kind;
    access_size_t sz;
    for (int a = 0; a < 256; a++) line_mem[a] = 8'((a * 13 + 90) ^ (a >> 3));
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b1;
    base = 0;

    test_name = "pass_through";
    run_op(0, 0, WORD, 32'h0, 32'h0, 5'd7, 1);
    if (cycles != 0) begin
      $display("[FAIL] %0s: latency exp 0 act %0d", test_name, cycles);
      tb_errors++;
    end
    run_op(0, 0, WORD, 32'h0, 32'h0, 5'd19, 0);
    finish_test();

    test_name = "store_load";
    run_op(0, 1, WORD, 32'h10, 32'hDEADBEEF, 5'd1, 0);
    run_op(0, 1, HALF, 32'h14, 32'h0000CAFE, 5'd2, 0);
    run_op(0, 1, BYTE, 32'h17, 32'h000000A5, 5'd3, 0);
    run_op(0, 1, BYTE, 32'h1A, 32'h0000003C, 5'd3, 0);
    for (int i = 0; i < 16; i++) run_op(1, 0, BYTE, 32'h10 + i, 0, 5'd4, 0);
    for (int i = 0; i < 16; i += 2) run_op(1, 0, HALF, 32'h10 + i, 0, 5'd5, 0);
    for (int i = 0; i < 16; i += 4) run_op(1, 0, WORD, 32'h10 + i, 0, 5'd6, 0);
    finish_test();

    test_name = "load_latency";
    run_op(1, 0, WORD, 32'h14, 0, 5'd8, 0);
    if (!timed_out && cycles != 1) begin
      $display("[FAIL] %0s: cycles exp 1 act %0d", test_name, cycles);
      tb_errors++;
    end
    finish_test();

    test_name = "conflict_evict";
    for (int i = 0; i < 4; i++) run_op(0, 1, WORD, 32'h20 + 64 * i, 32'h1000 + i, 5'd9, 0);
    for (int i = 0; i < 4; i++) run_op(1, 0, WORD, 32'h20 + 64 * i, 0, 5'd10, 0);
    run_op(1, 0, BYTE, 32'h23, 0, 5'd11, 0);
    finish_test();

    test_name = "random_mix";
    for (int n = 0; n < 200; n++) begin
      kind = 2'(rand_bits(2));
      sz   = access_size_t'(rand_bits(2) % 3);
      run_op(kind <= 1, kind == 2, sz, rand_bits(8) & ~((1 << int'(sz)) - 1),
             rand_bits(32), 5'(rand_bits(5)), rand_bits(1) == 1);
    end
    finish_test();

    $display("tests: %0d passed, %0d failed, %0d checks", n_pass, n_fail, checks);
    if (n_fail == 0 && !timed_out) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule : tb_mem_subsys

`default_nettype wire

//--- src/data_cache.sv
`timescale 1ns/1ps
`default_nettype none

module data_cache (
  input  logic        clk_i,
  input  logic        rst_i,
  dcache_cpu_if.cache cpu,
  dcache_mem_if.cache mem
);
  import mem_pkg::*;

  typedef enum logic [2:0] {
    ST_READY,
    ST_WB,
    ST_REQ,
    ST_WAIT,
    ST_INSTALL
  } state_t;

  state_t state_q, state_d;

  logic [TAG_BITS-1:0]   tag_q  [N_LINES];
  logic [LINE_WIDTH-1:0] line_q [N_LINES];
  logic [N_LINES-1:0]    valid_q;
  logic [N_LINES-1:0]    dirty_q;

  dcache_addr_u            cpu_a;
  dcache_addr_u            miss_a;
  logic                    miss_wr_q;
  logic [DATA_WIDTH-1:0]   miss_wdata_q;
  logic [DATA_WIDTH/8-1:0] miss_wstrb_q;
  logic [LINE_WIDTH-1:0]   fill_q;
  logic [LINE_WIDTH-1:0]   fill_merged;
  logic [LINE_WIDTH-1:0]   hit_line;
  logic [DATA_WIDTH-1:0]   rdata_q;
  logic                    rvalid_q;
  logic                    accept;

  // Byte lanes of one word replaced where strobed.
  function automatic logic [LINE_WIDTH-1:0] merge_word(
    input logic [LINE_WIDTH-1:0]   line,
    input logic [OFFSET_BITS-3:0]  word_sel,
    input logic [DATA_WIDTH-1:0]   wdata,
    input logic [DATA_WIDTH/8-1:0] wstrb
  );
    logic [LINE_WIDTH-1:0] merged;
    merged = line;
    for (int b = 0; b < DATA_WIDTH / 8; b++) begin
      if (wstrb[b]) begin
        merged[word_sel*DATA_WIDTH + b*8 +: 8] = wdata[b*8 +: 8];
      end
    end
    return merged;
  endfunction

  assign cpu_a.raw = cpu.addr;
  assign hit_line  = line_q[cpu_a.f.index];

  assign cpu.ready  = (state_q == ST_READY);
  assign cpu.hit    = valid_q[cpu_a.f.index] && (tag_q[cpu_a.f.index] == cpu_a.f.tag);
  assign cpu.rdata  = rdata_q;
  assign cpu.rvalid = rvalid_q;

  assign accept = cpu.req && cpu.ready;

  // Store data lands in the refilled line.
  assign fill_merged = merge_word(fill_q, miss_a.f.word_sel, miss_wdata_q, miss_wstrb_q);

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_READY: begin
        if (accept && !cpu.hit) begin
          if (valid_q[cpu_a.f.index] && dirty_q[cpu_a.f.index]) begin
            state_d = ST_WB;  // Evict first.
          end else begin
            state_d = ST_REQ;
          end
        end
      end
      ST_WB:      if (mem.gnt) state_d = ST_REQ;
      ST_REQ:     if (mem.gnt) state_d = ST_WAIT;
      ST_WAIT:    if (mem.rvalid) state_d = ST_INSTALL;
      ST_INSTALL: state_d = ST_READY;
      default:    state_d = ST_READY;
    endcase
  end

  // Line bus requests, held until granted.
  always_comb begin
    mem.req   = 1'b0;
    mem.we    = 1'b0;
    mem.addr  = '0;
    mem.wdata = line_q[miss_a.f.index];
    case (state_q)
      ST_WB: begin
        mem.req  = 1'b1;
        mem.we   = 1'b1;
        mem.addr = {tag_q[miss_a.f.index], miss_a.f.index, {OFFSET_BITS{1'b0}}};
      end
      ST_REQ: begin
        mem.req  = 1'b1;
        mem.addr = {miss_a.f.tag, miss_a.f.index, {OFFSET_BITS{1'b0}}};
      end
      default: begin
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      state_q  <= ST_READY;
      valid_q  <= '0;
      dirty_q  <= '0;
      rvalid_q <= 1'b0;
    end else begin
      state_q  <= state_d;
      rvalid_q <= 1'b0;
      if (accept && cpu.hit) begin
        rvalid_q <= !cpu.wr;
        if (cpu.wr) begin
          dirty_q[cpu_a.f.index] <= 1'b1;
        end
      end
      if (state_q == ST_INSTALL) begin
        valid_q[miss_a.f.index] <= 1'b1;
        dirty_q[miss_a.f.index] <= miss_wr_q;
        rvalid_q                <= !miss_wr_q;  // Load miss completes here.
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept && cpu.hit) begin
      rdata_q <= hit_line[cpu_a.f.word_sel*DATA_WIDTH +: DATA_WIDTH];
      if (cpu.wr) begin
        line_q[cpu_a.f.index] <= merge_word(hit_line, cpu_a.f.word_sel, cpu.wdata, cpu.wstrb);
      end
    end
    if (accept && !cpu.hit) begin
      miss_a       <= cpu_a;
      miss_wr_q    <= cpu.wr;
      miss_wdata_q <= cpu.wdata;
      miss_wstrb_q <= cpu.wr ? cpu.wstrb : '0;
    end
    if (state_q == ST_WAIT && mem.rvalid) begin
      fill_q <= mem.rdata;
    end
    if (state_q == ST_INSTALL) begin
      line_q[miss_a.f.index] <= fill_merged;
      tag_q[miss_a.f.index]  <= miss_a.f.tag;
      rdata_q                <= fill_merged[miss_a.f.word_sel*DATA_WIDTH +: DATA_WIDTH];
    end
  end

endmodule : data_cache

`default_nettype wire

//--- src/dcache_cpu_if.sv
`timescale 1ns/1ps
`default_nettype none

interface dcache_cpu_if;
  import mem_pkg::*;

  logic                    req;
  logic                    wr;
  logic [ADDR_WIDTH-1:0]   addr;   // Word aligned.
  logic [DATA_WIDTH-1:0]   wdata;  // Already lane shifted.
  logic [DATA_WIDTH/8-1:0] wstrb;
  logic                    ready;
  logic                    hit;
  logic [DATA_WIDTH-1:0]   rdata;
  logic                    rvalid;

  modport core (
    output req, wr, addr, wdata, wstrb,
    input  ready, hit, rdata, rvalid
  );

  modport cache (
    input  req, wr, addr, wdata, wstrb,
    output ready, hit, rdata, rvalid
  );

endinterface : dcache_cpu_if

`default_nettype wire

//--- src/dcache_mem_if.sv
`timescale 1ns/1ps
`default_nettype none

interface dcache_mem_if;
  import mem_pkg::*;

  logic                  req;
  logic                  we;
  logic [ADDR_WIDTH-1:0] addr;   // Line aligned.
  logic [LINE_WIDTH-1:0] wdata;
  logic                  gnt;
  logic                  rvalid;
  logic [LINE_WIDTH-1:0] rdata;

  modport cache (
    output req, we, addr, wdata,
    input  gnt, rvalid, rdata
  );

  modport port (
    input  req, we, addr, wdata,
    output gnt, rvalid, rdata
  );

endinterface : dcache_mem_if

`default_nettype wire

//--- src/mem_pkg.sv
`default_nettype none

package mem_pkg;

  localparam int ADDR_WIDTH     = 32;
  localparam int DATA_WIDTH     = 32;
  localparam int REGISTER_WIDTH = 5;

  // Cache geometry.
  localparam int LINE_BYTES  = 16;
  localparam int LINE_WIDTH  = LINE_BYTES * 8;
  localparam int N_LINES     = 4;
  localparam int OFFSET_BITS = $clog2(LINE_BYTES);
  localparam int INDEX_BITS  = $clog2(N_LINES);
  localparam int TAG_BITS    = ADDR_WIDTH - INDEX_BITS - OFFSET_BITS;

  typedef enum logic [1:0] {
    BYTE = 2'b00,
    HALF = 2'b01,
    WORD = 2'b10
  } access_size_t;

  // Field view of a byte address, MSB first.
  typedef struct packed {
    logic [TAG_BITS-1:0]    tag;
    logic [INDEX_BITS-1:0]  index;
    logic [OFFSET_BITS-3:0] word_sel;
    logic [1:0]             byte_sel;
  } dcache_addr_t;

  // Same 32 bits, read raw or split.
  typedef union packed {
    logic [ADDR_WIDTH-1:0] raw;
    dcache_addr_t          f;
  } dcache_addr_u;

endpackage : mem_pkg

`default_nettype wire

//--- src/mem_stage.sv
`timescale 1ns/1ps
`default_nettype none

module mem_stage (
  input  logic                               clk_i,
  input  logic                               rst_i,
  input  logic                               valid_i,
  input  logic                               is_load_i,
  input  logic                               is_store_i,
  input  logic                               reg_wr_en_i,
  input  mem_pkg::access_size_t              access_size_i,
  input  logic [mem_pkg::DATA_WIDTH-1:0]     alu_result_i,
  input  logic [mem_pkg::DATA_WIDTH-1:0]     rs2_data_i,
  input  logic [mem_pkg::REGISTER_WIDTH-1:0] wr_reg_i,
  output logic                               stall_o,
  output logic                               wb_valid_o,
  output logic                               wb_reg_wr_en_o,
  output logic                               wb_is_next_cycle_o,
  output logic [mem_pkg::REGISTER_WIDTH-1:0] wb_wr_reg_o,
  output logic [mem_pkg::DATA_WIDTH-1:0]     wb_data_from_mem_o,
  dcache_cpu_if.core                         cache
);
  import mem_pkg::*;

  typedef enum logic [1:0] {
    IDLE    = 2'b00,
    READY   = 2'b01,
    WAITING = 2'b10
  } state_t;

  state_t state, state_d;

  logic [1:0]            byte_off;
  logic [DATA_WIDTH-1:0] load_word;

  assign byte_off = alu_result_i[1:0];

  // Word address and store lanes.
  assign cache.addr  = {alu_result_i[DATA_WIDTH-1:2], 2'b00};
  assign cache.wdata = rs2_data_i << {byte_off, 3'b000};

  always_comb begin
    case (access_size_i)
      BYTE:    cache.wstrb = 4'b0001 << byte_off;
      HALF:    cache.wstrb = 4'b0011 << byte_off;
      default: cache.wstrb = 4'b1111;
    endcase
  end

  // Loaded lane moved down, zero extended.
  assign load_word = cache.rdata >> {byte_off, 3'b000};

  always_comb begin
    case (access_size_i)
      BYTE:    wb_data_from_mem_o = {24'b0, load_word[7:0]};
      HALF:    wb_data_from_mem_o = {16'b0, load_word[15:0]};
      default: wb_data_from_mem_o = load_word;
    endcase
  end

  assign wb_wr_reg_o        = wr_reg_i;
  assign wb_is_next_cycle_o = wb_valid_o;

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      state <= IDLE;
    end else begin
      state <= state_d;
    end
  end

  always_comb begin
    cache.req      = 1'b0;
    cache.wr       = 1'b0;
    wb_valid_o     = 1'b0;
    wb_reg_wr_en_o = 1'b0;
    stall_o        = 1'b0;
    state_d        = state;
    case (state)
      IDLE: begin
        stall_o = 1'b1;
        state_d = READY;
      end
      READY: begin
        if (valid_i && (is_load_i || is_store_i)) begin
          if (!cache.ready) begin
            stall_o = 1'b1;
          end else begin
            cache.req = 1'b1;
            cache.wr  = is_store_i;
            if (is_store_i && cache.hit) begin
              wb_valid_o     = 1'b1;
              wb_reg_wr_en_o = reg_wr_en_i;
            end else begin
              stall_o = 1'b1;
              state_d = WAITING;
            end
          end
        end else if (valid_i) begin
          wb_valid_o     = 1'b1;  // Pass-through.
          wb_reg_wr_en_o = reg_wr_en_i;
        end
      end
      WAITING: begin
        stall_o = 1'b1;
        if (is_load_i ? cache.rvalid : cache.hit) begin
          wb_valid_o     = 1'b1;
          wb_reg_wr_en_o = is_load_i | reg_wr_en_i;
          stall_o        = 1'b0;
          state_d        = READY;
        end
      end
      default: state_d = IDLE;
    endcase
  end

endmodule : mem_stage

`default_nettype wire

//--- src/mem_subsys_top.sv
`timescale 1ns/1ps
`default_nettype none

module mem_subsys_top (
  input  logic                               clk_i,
  input  logic                               rst_i,
  input  logic                               valid_i,
  input  logic                               is_load_i,
  input  logic                               is_store_i,
  input  logic                               reg_wr_en_i,
  input  mem_pkg::access_size_t              access_size_i,
  input  logic [mem_pkg::DATA_WIDTH-1:0]     alu_result_i,
  input  logic [mem_pkg::DATA_WIDTH-1:0]     rs2_data_i,
  input  logic [mem_pkg::REGISTER_WIDTH-1:0] wr_reg_i,
  input  logic                               mem_gnt_i,
  input  logic                               mem_rvalid_i,
  input  logic [mem_pkg::LINE_WIDTH-1:0]     mem_line_data_i,
  output logic                               stall_o,
  output logic                               wb_valid_o,
  output logic                               wb_reg_wr_en_o,
  output logic                               wb_is_next_cycle_o,
  output logic [mem_pkg::REGISTER_WIDTH-1:0] wb_wr_reg_o,
  output logic [mem_pkg::DATA_WIDTH-1:0]     wb_data_from_mem_o,
  output logic                               rd_req_valid_o,
  output logic                               wr_req_valid_o,
  output logic [mem_pkg::ADDR_WIDTH-1:0]     mem_req_address_o,
  output logic [mem_pkg::LINE_WIDTH-1:0]     wr_line_data_o
);

  dcache_cpu_if cpu_if ();
  dcache_mem_if mem_if ();

  mem_stage u_mem_stage (
    .clk_i              (clk_i),
    .rst_i              (rst_i),
    .valid_i            (valid_i),
    .is_load_i          (is_load_i),
    .is_store_i         (is_store_i),
    .reg_wr_en_i        (reg_wr_en_i),
    .access_size_i      (access_size_i),
    .alu_result_i       (alu_result_i),
    .rs2_data_i         (rs2_data_i),
    .wr_reg_i           (wr_reg_i),
    .stall_o            (stall_o),
    .wb_valid_o         (wb_valid_o),
    .wb_reg_wr_en_o     (wb_reg_wr_en_o),
    .wb_is_next_cycle_o (wb_is_next_cycle_o),
    .wb_wr_reg_o        (wb_wr_reg_o),
    .wb_data_from_mem_o (wb_data_from_mem_o),
    .cache              (cpu_if.core)
  );

  data_cache u_data_cache (
    .clk_i (clk_i),
    .rst_i (rst_i),
    .cpu   (cpu_if.cache),
    .mem   (mem_if.cache)
  );

  // Memory side of the line bus.
  assign rd_req_valid_o    = mem_if.req && !mem_if.we;
  assign wr_req_valid_o    = mem_if.req && mem_if.we;
  assign mem_req_address_o = mem_if.addr;
  assign wr_line_data_o    = mem_if.wdata;
  assign mem_if.gnt        = mem_gnt_i;
  assign mem_if.rvalid     = mem_rvalid_i;
  assign mem_if.rdata      = mem_line_data_i;

endmodule : mem_subsys_top

`default_nettype wire
